// File: sim.f
decode_pkg.sv
decoder_reg3.sv
decoder_imm12.sv
decoder_ctrl.sv
decoder_csr.sv
id_stage.sv
id_top.sv
id_top_asserts.sv
tb_id_top.sv

// File: Bender.yml
package:
  name: id_decode

sources:
  - decode_pkg.sv
  - decoder_reg3.sv
  - decoder_imm12.sv
  - decoder_ctrl.sv
  - decoder_csr.sv
  - id_stage.sv
  - id_top.sv
  - target: simulation
    files:
      - id_top_asserts.sv
      - tb_id_top.sv

// File: id_trace.txt
# pc instr fe_excp fe_num has_int plv | aluop alusel rd_valid rd_addr wr_valid wr_addr
# use_imm imm excp excp_num (all hex, rd_addr is {port1, port0})
1c000000 00100823 0 0 0 0 01 1 3 041 1 03 0 00000000 0 000
1c000004 001118a4 0 0 0 0 02 1 3 0c5 1 04 0 00000000 0 000
1c000008 00122507 0 0 0 0 03 1 3 128 1 07 0 00000000 0 000
1c00000c 00128c41 0 0 0 0 04 1 3 062 1 01 0 00000000 0 000
1c000010 0014316a 0 0 0 0 08 2 3 18b 1 0a 0 00000000 0 000
1c000014 00149cc5 0 0 0 0 05 2 3 0e6 1 05 0 00000000 0 000
1c000018 00150c41 0 0 0 0 06 2 3 062 1 01 0 00000000 0 000
1c00001c 00159062 0 0 0 0 07 2 3 083 1 02 0 00000000 0 000
1c000020 02bffc41 0 0 0 0 01 1 1 002 1 01 1 ffffffff 0 000
1c000024 021ffc83 0 0 0 0 03 1 1 004 1 03 1 000007ff 0 000
1c000028 026000c5 0 0 0 0 04 1 1 006 1 05 1 fffff800 0 000
1c00002c 037ffd07 0 0 0 0 05 2 1 008 1 07 1 00000fff 0 000
1c000030 03a00009 0 0 0 0 06 2 1 000 1 09 1 00000800 0 000
1c000034 03c48c21 0 0 0 0 07 2 1 001 1 01 1 00000123 0 000
1c000038 28bff064 0 0 0 0 12 4 1 003 1 04 1 fffffffc 0 000
1c00003c 298020c5 0 0 0 0 13 4 3 0a6 0 00 1 00000008 0 000
1c000040 58001022 0 0 0 0 0b 3 3 041 0 00 1 00000010 0 000
1c000044 5ffffc64 0 0 0 0 0c 3 3 083 0 00 1 fffffffc 0 000
1c000048 620000a6 0 0 0 0 0d 3 3 0c5 0 00 1 fffe0000 0 000
1c00004c 640400e8 0 0 0 0 0e 3 3 107 0 00 1 00000400 0 000
1c000050 4c0008a1 0 0 0 0 11 3 1 005 1 01 1 00000008 0 000
1c000054 50004000 0 0 0 0 0f 3 0 000 0 00 1 00000040 0 000
1c000058 57fffbff 0 0 0 0 10 3 0 000 1 01 1 fffffff8 0 000
1c00005c 142468a4 0 0 0 0 09 1 0 000 1 04 1 12345000 0 000
1c000060 1dffffe5 0 0 0 0 0a 1 0 000 1 05 1 fffff000 0 000
1c000064 04001404 0 0 0 0 14 5 0 000 1 04 1 00000005 0 000
1c000068 04000426 0 0 0 0 15 5 2 0c0 1 06 1 00000001 0 000
1c00006c 04040107 0 0 0 0 16 5 3 0e8 1 07 1 00000100 0 000
1c000070 04001404 0 0 0 3 00 0 0 000 0 00 0 00000000 1 100
1c000074 06483800 0 0 0 0 17 5 0 000 0 00 0 00000000 0 000
1c000078 06483800 0 0 0 3 00 0 0 000 0 00 0 00000000 1 100
1c00007c ffffffff 0 0 0 0 00 0 0 000 0 00 0 00000000 1 080
1c000080 002a0005 0 0 0 0 00 0 0 000 0 00 0 00000000 1 040
1c000084 002b0011 0 0 0 0 00 0 0 000 0 00 0 00000000 1 020
1c000088 00100823 0 0 1 0 01 1 3 041 1 03 0 00000000 1 001
1c00008c 00100823 1 5 0 0 00 0 0 000 0 00 0 00000000 1 00a

// File: tb_id_top.sv
`timescale 1ns/1ps

module tb_id_top
    import decode_pkg::*;
();

    localparam int MAX_ENTRIES  = 64;
    localparam int TIMEOUT      = 200;
    // Cycles in which dispatch_ready_i is held high
    localparam int STEADY_FIRST = 40;
    localparam int STEADY_END   = 60;

    logic       clk;
    logic       rst_n_i;
    logic       ib_valid_i;
    ib_entry_t  ib_entry_i;
    logic       ib_ready_o;
    logic       has_int_i;
    logic [1:0] csr_plv_i;
    logic       dispatch_valid_o;
    dispatch_t  dispatch_o;
    logic       dispatch_ready_i;

    ib_entry_t  stim_entry [MAX_ENTRIES];
    logic       stim_int   [MAX_ENTRIES];
    logic [1:0] stim_plv   [MAX_ENTRIES];
    dispatch_t  expected   [MAX_ENTRIES];
    int         n_entries;
    logic [31:0] lfsr_state;
    int          cycle;

    id_top i_id_top (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .ib_valid_i       (ib_valid_i),
        .ib_entry_i       (ib_entry_i),
        .ib_ready_o       (ib_ready_o),
        .has_int_i        (has_int_i),
        .csr_plv_i        (csr_plv_i),
        .dispatch_valid_o (dispatch_valid_o),
        .dispatch_o       (dispatch_o),
        .dispatch_ready_i (dispatch_ready_i)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic stop_on_error();
        $display("Something failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_op(input alu_op_e exp_op, input alu_op_e act_op,
                            input alu_sel_e exp_sel, input alu_sel_e act_sel);
        if (exp_op !== act_op) begin
            $display("FAILED at %0t: dispatch_o.aluop expected %h got %h", $time, exp_op, act_op);
            stop_on_error();
        end
        if (exp_sel !== act_sel) begin
            $display("FAILED at %0t: dispatch_o.alusel expected %h got %h",
                     $time, exp_sel, act_sel);
            stop_on_error();
        end
    endtask

    task automatic check_regs(input string name, input logic [2*REG_ADDR_W-1:0] exp_val,
                              input logic [2*REG_ADDR_W-1:0] act_val);
        if (exp_val !== act_val) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
            stop_on_error();
        end
    endtask

    task automatic check_imm(input string name, input logic [XLEN-1:0] exp_val,
                             input logic [XLEN-1:0] act_val);
        if (exp_val !== act_val) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
            stop_on_error();
        end
    endtask

    task automatic check_excp(input logic exp_excp, input logic act_excp,
                              input logic [EXCP_W-1:0] exp_num,
                              input logic [EXCP_W-1:0] act_num);
        if (exp_excp !== act_excp || exp_num !== act_num) begin
            $display("FAILED at %0t: dispatch_o.excp/excp_num expected %b/%h got %b/%h",
                     $time, exp_excp, exp_num, act_excp, act_num);
            stop_on_error();
        end
    endtask

    task automatic read_trace();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f [16];
        fd = $fopen("id_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file id_trace.txt");
            stop_on_error();
        end
        n_entries = 0;
        while (!$feof(fd) && n_entries < MAX_ENTRIES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                              f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                if (cnt == 16) begin
                    stim_entry[n_entries] = {f[0], f[1], f[2][0], f[3][3:0]};
                    stim_int[n_entries]   = f[4][0];
                    stim_plv[n_entries]   = f[5][1:0];
                    expected[n_entries]   = {f[0], f[1], alu_op_e'(f[6][5:0]),
                                             alu_sel_e'(f[7][2:0]), f[8][1:0], f[9][9:0],
                                             f[10][0], f[11][4:0], f[12][0], f[13],
                                             f[14][0], f[15][EXCP_W-1:0]};
                    n_entries++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_entries();
        int waited;
        for (int i = 0; i < n_entries; i++) begin
            ib_valid_i = 1'b1;
            ib_entry_i = stim_entry[i];
            has_int_i  = stim_int[i];
            csr_plv_i  = stim_plv[i];
            waited     = 0;
            do begin
                @(negedge clk);
                waited++;
                if (waited > TIMEOUT) begin
                    $display("Timed out waiting for ib_ready_o on the instruction buffer side");
                    stop_on_error();
                end
            end while (!ib_ready_o);
            @(posedge clk);
            #2;
        end
        ib_valid_i = 1'b0;
    endtask

    task automatic collect_results();
        int        waited;
        int        last_cycle;
        dispatch_t exp;
        last_cycle = -1;
        for (int i = 0; i < n_entries; i++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
                if (waited > TIMEOUT) begin
                    $display("Timed out waiting for a transfer on the dispatch side");
                    stop_on_error();
                end
            end while (!(dispatch_valid_o && dispatch_ready_i));
            // With ready held high, the next result follows in the very next cycle
            if (last_cycle >= STEADY_FIRST && last_cycle <= STEADY_END - 2
                && cycle != last_cycle + 1) begin
                $display("A cycle passed without a result while dispatch_ready_i was held high");
                stop_on_error();
            end
            last_cycle = cycle;
            exp = expected[i];
            check_imm("dispatch_o.pc", exp.pc, dispatch_o.pc);
            check_imm("dispatch_o.instr", exp.instr, dispatch_o.instr);
            check_op(exp.aluop, dispatch_o.aluop, exp.alusel, dispatch_o.alusel);
            check_regs("dispatch_o.reg_read_valid", 10'(exp.reg_read_valid),
                       10'(dispatch_o.reg_read_valid));
            check_regs("dispatch_o.reg_read_addr", exp.reg_read_addr, dispatch_o.reg_read_addr);
            check_regs("dispatch_o.reg_write", {4'b0, exp.reg_write_valid, exp.reg_write_addr},
                       {4'b0, dispatch_o.reg_write_valid, dispatch_o.reg_write_addr});
            check_imm("dispatch_o.use_imm", 32'(exp.use_imm), 32'(dispatch_o.use_imm));
            check_imm("dispatch_o.imm", exp.imm, dispatch_o.imm);
            check_excp(exp.excp, dispatch_o.excp, exp.excp_num, dispatch_o.excp_num);
        end
        // The last result must not come out a second time
        @(negedge clk);
        if (dispatch_valid_o !== 1'b0) begin
            $display("FAILED at %0t: dispatch_valid_o expected 0 got %b", $time, dispatch_valid_o);
            stop_on_error();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // A failed handshake assertion in the bound checker ends the run
    always @(posedge i_id_top.i_id_top_asserts.assert_failed) begin
        $display("A handshake assertion on id_top failed");
        stop_on_error();
    end

    // Random back-pressure, with a stretch of steady ready
    initial begin
        lfsr_state = 32'hfc87;
        cycle      = 0;
        forever begin
            @(posedge clk);
            #2;
            cycle++;
            if (cycle >= STEADY_FIRST && cycle < STEADY_END) begin
                dispatch_ready_i = 1'b1;
            end else begin
                lfsr_state       = lfsr_step(lfsr_state);
                dispatch_ready_i = lfsr_state[0];
            end
        end
    end

    initial begin
        rst_n_i          = 1'b0;
        ib_valid_i       = 1'b0;
        ib_entry_i       = '0;
        has_int_i        = 1'b0;
        csr_plv_i        = 2'd0;
        dispatch_ready_i = 1'b0;
        read_trace();
        repeat (2) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        fork
            drive_entries();
            collect_results();
        join
        if (n_entries == 0) begin
            $display("The trace held no entries");
            stop_on_error();
        end else begin
            $display("Everything OK");
        end
        $finish;
    end

endmodule

// File: id_top_asserts.sv
`timescale 1ns/1ps

module id_top_asserts
    import decode_pkg::*;
(
    input logic      clk,
    input logic      rst_n_i,
    input logic      ib_ready_o,
    input logic      dispatch_valid_o,
    input dispatch_t dispatch_o,
    input logic      dispatch_ready_i
);

    // Set when any assertion below fails
    logic assert_failed = 1'b0;

    // Register is empty in the cycle after reset
    a_valid_after_reset: assert property (@(posedge clk)
        !rst_n_i |=> !dispatch_valid_o)
        else begin
            assert_failed = 1'b1;
            $error("dispatch_valid_o high after reset");
        end

    // A stalled result keeps its valid and its data
    a_dispatch_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        dispatch_valid_o && !dispatch_ready_i |=> dispatch_valid_o && $stable(dispatch_o))
        else begin
            assert_failed = 1'b1;
            $error("dispatch_o changed while stalled");
        end

    // Ready when empty or when the dispatch side takes the result
    a_ready_rule: assert property (@(posedge clk) disable iff (!rst_n_i)
        ib_ready_o == (!dispatch_valid_o || dispatch_ready_i))
        else begin
            assert_failed = 1'b1;
            $error("ib_ready_o does not follow the ready rule");
        end

endmodule

bind id_top id_top_asserts i_id_top_asserts (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .ib_ready_o       (ib_ready_o),
    .dispatch_valid_o (dispatch_valid_o),
    .dispatch_o       (dispatch_o),
    .dispatch_ready_i (dispatch_ready_i)
);

// File: id_top.sv
`timescale 1ns/1ps

module id_top
    import decode_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       ib_valid_i,
    input  ib_entry_t  ib_entry_i,
    output logic       ib_ready_o,
    input  logic       has_int_i,
    input  logic [1:0] csr_plv_i,
    output logic       dispatch_valid_o,
    output dispatch_t  dispatch_o,
    input  logic       dispatch_ready_i
);

    instr_word_u dec_instr;
    sub_decode_t reg3_res;
    sub_decode_t imm12_res;
    sub_decode_t ctrl_res;
    sub_decode_t csr_res;

    id_stage u_id_stage (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .ib_valid_i       (ib_valid_i),
        .ib_entry_i       (ib_entry_i),
        .ib_ready_o       (ib_ready_o),
        .has_int_i        (has_int_i),
        .csr_plv_i        (csr_plv_i),
        .dec_instr_o      (dec_instr),
        .reg3_i           (reg3_res),
        .imm12_i          (imm12_res),
        .ctrl_i           (ctrl_res),
        .csr_i            (csr_res),
        .dispatch_valid_o (dispatch_valid_o),
        .dispatch_o       (dispatch_o),
        .dispatch_ready_i (dispatch_ready_i)
    );

    decoder_reg3 u_decoder_reg3 (
        .instr_i  (dec_instr),
        .result_o (reg3_res)
    );

    decoder_imm12 u_decoder_imm12 (
        .instr_i  (dec_instr),
        .result_o (imm12_res)
    );

    decoder_ctrl u_decoder_ctrl (
        .instr_i  (dec_instr),
        .result_o (ctrl_res)
    );

    decoder_csr u_decoder_csr (
        .instr_i  (dec_instr),
        .result_o (csr_res)
    );

endmodule

// File: id_stage.sv
`timescale 1ns/1ps

module id_stage
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,

    // Instruction buffer side
    input  logic        ib_valid_i,
    input  ib_entry_t   ib_entry_i,
    output logic        ib_ready_o,

    // Interrupt and privilege from CSR
    input  logic        has_int_i,
    input  logic [1:0]  csr_plv_i,

    // Format decoders
    output instr_word_u dec_instr_o,
    input  sub_decode_t reg3_i,
    input  sub_decode_t imm12_i,
    input  sub_decode_t ctrl_i,
    input  sub_decode_t csr_i,

    // Dispatch side
    output logic        dispatch_valid_o,
    output dispatch_t   dispatch_o,
    input  logic        dispatch_ready_i
);

    sub_decode_t       merged;
    logic              excp_ine;
    logic              excp_ipe;
    logic              excp_nop;
    logic [EXCP_W-1:0] excp_num;
    logic              accept;
    dispatch_t         dispatch_d;

    // Decoders only see a word when the entry is valid
    assign dec_instr_o = ib_valid_i ? ib_entry_i.instr : '0;

    // At most one decoder matches, the rest return zero
    assign merged = reg3_i | imm12_i | ctrl_i | csr_i;

    assign excp_ine = ib_valid_i & ~merged.valid;
    assign excp_ipe = merged.kernel & (csr_plv_i == PLV_USER);
    assign excp_nop = excp_ipe | excp_ine | ib_entry_i.excp;

    assign excp_num = {excp_ipe, excp_ine, merged.is_break, merged.is_syscall,
                       ib_entry_i.excp_num, has_int_i};

    always_comb begin
        dispatch_d          = '0;
        dispatch_d.pc       = ib_entry_i.pc;
        dispatch_d.instr    = ib_entry_i.instr;
        dispatch_d.excp     = excp_ipe | excp_ine | merged.is_break | merged.is_syscall
                            | ib_entry_i.excp | has_int_i;
        dispatch_d.excp_num = excp_num;
        // Excepting instructions still flow on as NOPs so the exception gets handled
        if (!excp_nop) begin
            dispatch_d.aluop           = merged.aluop;
            dispatch_d.alusel          = merged.alusel;
            dispatch_d.reg_read_valid  = merged.reg_read_valid;
            dispatch_d.reg_read_addr   = merged.reg_read_addr;
            dispatch_d.reg_write_valid = merged.reg_write_valid;
            dispatch_d.reg_write_addr  = merged.reg_write_addr;
            dispatch_d.use_imm         = merged.use_imm;
            dispatch_d.imm             = merged.imm;
        end
    end

    // Take a new entry whenever the register empties on this edge
    assign ib_ready_o = ~dispatch_valid_o | dispatch_ready_i;
    assign accept     = ib_valid_i & ib_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dispatch_valid_o <= 1'b0;
        end else if (ib_ready_o) begin
            dispatch_valid_o <= ib_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dispatch_o <= dispatch_d;
        end
    end

endmodule

// File: decoder_csr.sv
`timescale 1ns/1ps

module decoder_csr
    import decode_pkg::*;
(
    input  instr_word_u instr_i,
    output sub_decode_t result_o
);

    logic csr_space;
    logic is_ertn;

    assign csr_space = instr_i.ri14.opcode8 == 8'h04;
    assign is_ertn   = instr_i == 32'h0648_3800;

    always_comb begin
        result_o = '0;
        if (csr_space) begin
            result_o.valid           = 1'b1;
            result_o.kernel          = 1'b1;
            result_o.alusel          = SEL_CSR;
            result_o.use_imm         = 1'b1;
            result_o.imm             = {18'b0, instr_i.ri14.csr14};
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = instr_i.ri14.rd;
            // rj of 0 and 1 pick csrrd and csrwr, anything else is csrxchg with rj as mask
            case (instr_i.ri14.rj)
                5'd0: result_o.aluop = OP_CSRRD;
                5'd1: begin
                    result_o.aluop          = OP_CSRWR;
                    result_o.reg_read_valid = 2'b10;
                    result_o.reg_read_addr  = {instr_i.ri14.rd, 5'd0};
                end
                default: begin
                    result_o.aluop          = OP_CSRXCHG;
                    result_o.reg_read_valid = 2'b11;
                    result_o.reg_read_addr  = {instr_i.ri14.rd, instr_i.ri14.rj};
                end
            endcase
        end else if (is_ertn) begin
            result_o.valid  = 1'b1;
            result_o.kernel = 1'b1;
            result_o.aluop  = OP_ERTN;
            result_o.alusel = SEL_CSR;
        end
    end

endmodule

// File: decoder_ctrl.sv
`timescale 1ns/1ps

module decoder_ctrl
    import decode_pkg::*;
(
    input  instr_word_u instr_i,
    output sub_decode_t result_o
);

    logic [XLEN-1:0] offs16_ext;
    logic [XLEN-1:0] offs26_ext;
    logic [XLEN-1:0] imm20_hi;

    // Branch offsets count words
    assign offs16_ext = {{14{instr_i.ri16.offs16[15]}}, instr_i.ri16.offs16, 2'b00};
    assign offs26_ext = {{4{instr_i.i26.offs_hi10[9]}}, instr_i.i26.offs_hi10,
                         instr_i.i26.offs_lo16, 2'b00};
    assign imm20_hi   = {instr_i.ri20.imm20, 12'b0};

    always_comb begin
        logic cond_br;

        cond_br  = 1'b0;
        result_o = '0;
        case (instr_i.ri16.opcode6)
            6'h13: begin
                result_o.aluop           = OP_JIRL;
                result_o.reg_read_valid  = 2'b01;
                result_o.reg_read_addr   = {5'd0, instr_i.ri16.rj};
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr  = instr_i.ri16.rd;
                result_o.imm             = offs16_ext;
            end
            6'h14: begin
                result_o.aluop = OP_B;
                result_o.imm   = offs26_ext;
            end
            // bl links into r1
            6'h15: begin
                result_o.aluop           = OP_BL;
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr  = 5'd1;
                result_o.imm             = offs26_ext;
            end
            6'h16: begin
                result_o.aluop = OP_BEQ;
                cond_br        = 1'b1;
            end
            6'h17: begin
                result_o.aluop = OP_BNE;
                cond_br        = 1'b1;
            end
            6'h18: begin
                result_o.aluop = OP_BLT;
                cond_br        = 1'b1;
            end
            6'h19: begin
                result_o.aluop = OP_BGE;
                cond_br        = 1'b1;
            end
            default: ;
        endcase

        // Conditional branches compare rj with rd
        if (cond_br) begin
            result_o.reg_read_valid = 2'b11;
            result_o.reg_read_addr  = {instr_i.ri16.rd, instr_i.ri16.rj};
            result_o.imm            = offs16_ext;
        end
        if (result_o.aluop != OP_NOP) begin
            result_o.valid   = 1'b1;
            result_o.alusel  = SEL_BRANCH;
            result_o.use_imm = 1'b1;
        end

        if (instr_i.ri20.opcode7 == 7'h0a || instr_i.ri20.opcode7 == 7'h0e) begin
            result_o.valid           = 1'b1;
            result_o.aluop           = instr_i.ri20.opcode7[2] ? OP_PCADDU12I : OP_LU12I;
            result_o.alusel          = SEL_ARITH;
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = instr_i.ri20.rd;
            result_o.use_imm         = 1'b1;
            result_o.imm             = imm20_hi;
        end
    end

endmodule

// File: decoder_imm12.sv
`timescale 1ns/1ps

module decoder_imm12
    import decode_pkg::*;
(
    input  instr_word_u instr_i,
    output sub_decode_t result_o
);

    logic            hit;
    logic            zext;
    logic            is_store;
    alu_op_e         op;
    alu_sel_e        sel;
    logic [XLEN-1:0] imm_ext;

    always_comb begin
        hit      = 1'b1;
        zext     = 1'b0;
        is_store = 1'b0;
        op       = OP_NOP;
        sel      = SEL_ARITH;
        case (instr_i.ri12.opcode10)
            10'h008: op = OP_SLT;
            10'h009: op = OP_SLTU;
            10'h00a: op = OP_ADD;
            // Logic immediates are unsigned
            10'h00d: begin
                op   = OP_AND;
                sel  = SEL_LOGIC;
                zext = 1'b1;
            end
            10'h00e: begin
                op   = OP_OR;
                sel  = SEL_LOGIC;
                zext = 1'b1;
            end
            10'h00f: begin
                op   = OP_XOR;
                sel  = SEL_LOGIC;
                zext = 1'b1;
            end
            10'h0a2: begin
                op  = OP_LD_W;
                sel = SEL_MEM;
            end
            10'h0a6: begin
                op       = OP_ST_W;
                sel      = SEL_MEM;
                is_store = 1'b1;
            end
            default: begin
                hit = 1'b0;
                sel = SEL_NONE;
            end
        endcase
    end

    assign imm_ext = zext ? {20'b0, instr_i.ri12.imm12}
                          : {{20{instr_i.ri12.imm12[11]}}, instr_i.ri12.imm12};

    always_comb begin
        result_o = '0;
        if (hit) begin
            result_o.valid   = 1'b1;
            result_o.aluop   = op;
            result_o.alusel  = sel;
            result_o.use_imm = 1'b1;
            result_o.imm     = imm_ext;
            // A store reads its data from rd on port 1
            result_o.reg_read_valid  = {is_store, 1'b1};
            result_o.reg_read_addr   = {is_store ? instr_i.ri12.rd : 5'd0, instr_i.ri12.rj};
            result_o.reg_write_valid = ~is_store;
            result_o.reg_write_addr  = is_store ? 5'd0 : instr_i.ri12.rd;
        end
    end

endmodule

// File: decoder_reg3.sv
`timescale 1ns/1ps

module decoder_reg3
    import decode_pkg::*;
(
    input  instr_word_u instr_i,
    output sub_decode_t result_o
);

    logic     alu_hit;
    logic     is_break;
    logic     is_syscall;
    alu_op_e  op;
    alu_sel_e sel;

    // Opcode lookup for the register-register ALU group
    always_comb begin
        alu_hit = 1'b1;
        op      = OP_NOP;
        sel     = SEL_ARITH;
        case (instr_i.r3.opcode17)
            17'h00020: op = OP_ADD;
            17'h00022: op = OP_SUB;
            17'h00024: op = OP_SLT;
            17'h00025: op = OP_SLTU;
            17'h00028: begin
                op  = OP_NOR;
                sel = SEL_LOGIC;
            end
            17'h00029: begin
                op  = OP_AND;
                sel = SEL_LOGIC;
            end
            17'h0002a: begin
                op  = OP_OR;
                sel = SEL_LOGIC;
            end
            17'h0002b: begin
                op  = OP_XOR;
                sel = SEL_LOGIC;
            end
            default: begin
                alu_hit = 1'b0;
                sel     = SEL_NONE;
            end
        endcase
    end

    // The low 15 bits of break and syscall hold a code, not registers
    assign is_break   = instr_i.r3.opcode17 == 17'h00054;
    assign is_syscall = instr_i.r3.opcode17 == 17'h00056;

    always_comb begin
        result_o            = '0;
        result_o.valid      = alu_hit | is_break | is_syscall;
        result_o.is_break   = is_break;
        result_o.is_syscall = is_syscall;
        if (alu_hit) begin
            result_o.aluop           = op;
            result_o.alusel          = sel;
            result_o.reg_read_valid  = 2'b11;
            result_o.reg_read_addr   = {instr_i.r3.rk, instr_i.r3.rj};
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = instr_i.r3.rd;
        end
    end

endmodule

// File: decode_pkg.sv
package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Exception vector, MSB first: ipe, ine, break, syscall, frontend[3:0], int
    localparam int EXCP_W = 9;

    // Privilege level of user mode
    localparam logic [1:0] PLV_USER = 2'd3;

    // Operation code, zero is a NOP
    typedef enum logic [5:0] {
        OP_NOP = 6'd0,
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_LU12I, OP_PCADDU12I,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
        OP_B, OP_BL, OP_JIRL,
        OP_LD_W, OP_ST_W,
        OP_CSRRD, OP_CSRWR, OP_CSRXCHG, OP_ERTN,
        OP_BREAK, OP_SYSCALL
    } alu_op_e;

    // Functional unit
    typedef enum logic [2:0] {
        SEL_NONE = 3'd0,
        SEL_ARITH,
        SEL_LOGIC,
        SEL_BRANCH,
        SEL_MEM,
        SEL_CSR
    } alu_sel_e;

    // One instruction word seen through each LA32R format
    typedef union packed {
        struct packed {
            logic [16:0]           opcode17;
            logic [REG_ADDR_W-1:0] rk;
            logic [REG_ADDR_W-1:0] rj;
            logic [REG_ADDR_W-1:0] rd;
        } r3;
        struct packed {
            logic [9:0]            opcode10;
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rj;
            logic [REG_ADDR_W-1:0] rd;
        } ri12;
        struct packed {
            logic [5:0]            opcode6;
            logic [15:0]           offs16;
            logic [REG_ADDR_W-1:0] rj;
            logic [REG_ADDR_W-1:0] rd;
        } ri16;
        struct packed {
            logic [6:0]            opcode7;
            logic [19:0]           imm20;
            logic [REG_ADDR_W-1:0] rd;
        } ri20;
        struct packed {
            logic [5:0]  opcode6;
            logic [15:0] offs_lo16;
            logic [9:0]  offs_hi10;
        } i26;
        // CSR access, rj selects between csrrd, csrwr and csrxchg
        struct packed {
            logic [7:0]            opcode8;
            logic [13:0]           csr14;
            logic [REG_ADDR_W-1:0] rj;
            logic [REG_ADDR_W-1:0] rd;
        } ri14;
    } instr_word_u;

    // Instruction buffer entry
    typedef struct packed {
        logic [XLEN-1:0] pc;
        instr_word_u     instr;
        logic            excp;
        logic [3:0]      excp_num;
    } ib_entry_t;

    // Result of one format decoder, all zero when nothing matched
    // Read port 0 sits in the low half of reg_read_addr, port 1 in the high half
    typedef struct packed {
        logic                    valid;
        alu_op_e                 aluop;
        alu_sel_e                alusel;
        logic [1:0]              reg_read_valid;
        logic [2*REG_ADDR_W-1:0] reg_read_addr;
        logic                    reg_write_valid;
        logic [REG_ADDR_W-1:0]   reg_write_addr;
        logic                    use_imm;
        logic [XLEN-1:0]         imm;
        logic                    kernel;
        logic                    is_break;
        logic                    is_syscall;
    } sub_decode_t;

    // Decoded instruction handed to dispatch
    typedef struct packed {
        logic [XLEN-1:0]         pc;
        instr_word_u             instr;
        alu_op_e                 aluop;
        alu_sel_e                alusel;
        logic [1:0]              reg_read_valid;
        logic [2*REG_ADDR_W-1:0] reg_read_addr;
        logic                    reg_write_valid;
        logic [REG_ADDR_W-1:0]   reg_write_addr;
        logic                    use_imm;
        logic [XLEN-1:0]         imm;
        logic                    excp;
        logic [EXCP_W-1:0]       excp_num;
    } dispatch_t;

endpackage
